// File: hdl/dispatch_stage.sv
// Dispatch skid stage

`timescale 1ns/1ps

module dispatch_stage
  import ooo_bus_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  logic  disp_valid,
  output logic  disp_ready,
  input  inst_t disp_inst,
  rename_if.src out
);
  logic  skid_full;
  inst_t skid_inst;
  logic  armed;     // Opens the stream one cycle after reset
  logic  take, give;

  // Rename ready depends only on registered state and closes
  // no loop back to the dispatch stream
  assign disp_ready = armed && (!skid_full || out.ready);
  assign take       = disp_valid && disp_ready;
  assign give       = skid_full && out.ready;

  assign out.valid = skid_full;
  assign out.inst  = skid_inst;

  always_ff @(posedge clock) begin
    if (reset) begin
      armed     <= 1'b0;
      skid_full <= 1'b0;
    end else begin
      armed <= 1'b1;
      if (take)      skid_full <= 1'b1; // Refill even while passing on
      else if (give) skid_full <= 1'b0;
    end
  end

  // Skid payload
  always_ff @(posedge clock) begin
    if (take) skid_inst <= disp_inst;
  end
endmodule

// File: hdl/ooo_bus_pkg.sv
// Stage record types

package ooo_bus_pkg;

  import ooo_types_pkg::*;

  // Dispatched instruction
  typedef struct packed {
    arch_reg_t dest;
    arch_reg_t src1;
    arch_reg_t src2;
  } inst_t;

  // One reorder buffer slot
  typedef struct packed {
    arch_reg_t dest;
    phys_tag_t tag;     // Newly allocated tag
    phys_tag_t old_tag; // Previous mapping freed at retire
  } rob_entry_t;

  // Record leaving the ROB head
  typedef struct packed {
    arch_reg_t dest;
    phys_tag_t tag;
    phys_tag_t old_tag;
  } retire_rec_t;

  // Renamed instruction sent to the execution units
  typedef struct packed {
    rob_idx_t  rob_idx;
    phys_tag_t dest_tag;
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
  } issue_rec_t;

endpackage

// File: hdl/ooo_core.sv
// Out-of-order core top

`timescale 1ns/1ps

module ooo_core
  import ooo_types_pkg::*;
  import ooo_bus_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  // Dispatch stream
  input  logic        disp_valid,
  output logic        disp_ready,
  input  arch_reg_t   disp_dest,
  input  arch_reg_t   disp_src1,
  input  arch_reg_t   disp_src2,
  // Issue pulse
  output logic        iss_valid,
  output rob_idx_t    iss_rob_idx,
  output phys_tag_t   iss_dest_tag,
  output phys_tag_t   iss_src1_tag,
  output phys_tag_t   iss_src2_tag,
  // Completion pulse
  input  logic        cmp_valid,
  input  rob_idx_t    cmp_rob_idx,
  // Retire stream
  output logic        ret_valid,
  input  logic        ret_ready,
  output arch_reg_t   ret_arch,
  output phys_tag_t   ret_tag,
  output phys_tag_t   ret_old_tag,
  output logic [15:0] retired_count
);
  inst_t       disp_inst;
  issue_rec_t  iss_rec;
  retire_rec_t ret_rec;
  logic        alloc_valid, rob_full, free_valid;
  rob_entry_t  alloc_entry;
  rob_idx_t    tail_idx;
  phys_tag_t   free_tag;

  rename_if u_rename_if ();
  retire_if u_retire_if ();

  assign disp_inst    = '{dest: disp_dest, src1: disp_src1, src2: disp_src2};
  assign iss_rob_idx  = iss_rec.rob_idx;
  assign iss_dest_tag = iss_rec.dest_tag;
  assign iss_src1_tag = iss_rec.src1_tag;
  assign iss_src2_tag = iss_rec.src2_tag;
  assign ret_arch     = ret_rec.dest;
  assign ret_tag      = ret_rec.tag;
  assign ret_old_tag  = ret_rec.old_tag;

  dispatch_stage u_dispatch_stage (
    .clock(clock), .reset(reset), .disp_valid(disp_valid), .disp_ready(disp_ready),
    .disp_inst(disp_inst), .out(u_rename_if.src)
  );

  rename_unit u_rename_unit (
    .clock(clock), .reset(reset), .in(u_rename_if.dst), .rob_full(rob_full),
    .tail_idx(tail_idx), .alloc_valid(alloc_valid), .alloc_entry(alloc_entry),
    .free_valid(free_valid), .free_tag(free_tag), .iss_valid(iss_valid), .iss_rec(iss_rec)
  );

  reorder_buffer u_reorder_buffer (
    .clock(clock), .reset(reset), .alloc_valid(alloc_valid), .alloc_entry(alloc_entry),
    .cmp_valid(cmp_valid), .cmp_idx(cmp_rob_idx), .rob_full(rob_full),
    .tail_idx(tail_idx), .ret(u_retire_if.src)
  );

  retire_stage u_retire_stage (
    .clock(clock), .reset(reset), .in(u_retire_if.dst), .free_valid(free_valid),
    .free_tag(free_tag), .ret_valid(ret_valid), .ret_ready(ret_ready),
    .ret_rec(ret_rec), .retired_count(retired_count)
  );
endmodule

// File: hdl/ooo_types_pkg.sv
// Core index types

`include "ooo_macros.svh"

package ooo_types_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Register and tag widths follow the sizing macros
  ////////////////////////////////////////////////////////////////////////////

  // Architectural register number
  typedef logic [$clog2(`OOO_NUM_ARCH)-1:0] arch_reg_t;

  // Physical tag
  typedef logic [$clog2(`OOO_NUM_PR)-1:0] phys_tag_t;

  typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_idx_t; // ROB slot

endpackage

// File: hdl/rename_if.sv
// Stage handshake interfaces

`timescale 1ns/1ps

// One instruction per handshake from dispatch to rename
interface rename_if
  import ooo_bus_pkg::*;
();
  logic  valid;
  logic  ready;
  inst_t inst;

  modport src (output valid, output inst, input ready);
  modport dst (input valid, input inst, output ready);
endinterface

// ROB head to retire stage
interface retire_if
  import ooo_bus_pkg::*;
();
  logic        valid;
  logic        ready;
  retire_rec_t rec;

  modport src (output valid, output rec, input ready);
  modport dst (input valid, input rec, output ready);
endinterface

// File: hdl/rename_unit.sv
// Register rename unit

`timescale 1ns/1ps

`include "ooo_macros.svh"

module rename_unit
  import ooo_types_pkg::*;
  import ooo_bus_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  rename_if.dst      in,
  input  logic       rob_full,
  input  rob_idx_t   tail_idx,
  output logic       alloc_valid,
  output rob_entry_t alloc_entry,
  input  logic       free_valid,
  input  phys_tag_t  free_tag,
  output logic       iss_valid,
  output issue_rec_t iss_rec
);
  localparam int FL_DEPTH = `OOO_NUM_PR - `OOO_NUM_ARCH;

  phys_tag_t                   map_q [`OOO_NUM_ARCH];
  logic [$clog2(FL_DEPTH):0]   fill_cnt;
  logic                        fill_busy;
  logic                        fl_push, fl_empty;
  phys_tag_t                   fl_push_tag, fl_head;
  logic                        take;

  ////////////////////////////////////////////////////////////////////////////
  // Free list loaded with the spare tags right after reset
  ////////////////////////////////////////////////////////////////////////////

  assign fill_busy   = (fill_cnt < FL_DEPTH);
  assign fl_push     = fill_busy || free_valid;
  assign fl_push_tag = fill_busy ? phys_tag_t'(`OOO_NUM_ARCH + fill_cnt) : free_tag;

  ring_queue #(
    .payload_t (phys_tag_t),
    .DEPTH     (FL_DEPTH)
  ) u_free_list (
    .clock     (clock),
    .reset     (reset),
    .push      (fl_push),
    .push_data (fl_push_tag),
    .pop       (take),
    .pop_data  (fl_head),
    .empty     (fl_empty),
    .full      ()
  );

  assign in.ready = !fill_busy && !fl_empty && !rob_full;
  assign take     = in.valid && in.ready;

  // ROB allocation in the same cycle as the rename
  assign alloc_valid         = take;
  assign alloc_entry.dest    = in.inst.dest;
  assign alloc_entry.tag     = fl_head;
  assign alloc_entry.old_tag = map_q[in.inst.dest];

  ////////////////////////////////////////////////////////////////////////////
  // Map table and issue register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      fill_cnt  <= '0;
      iss_valid <= 1'b0;
      for (int r = 0; r < `OOO_NUM_ARCH; r++) begin
        map_q[r] <= phys_tag_t'(r); // Identity mapping
      end
    end else begin
      if (fill_busy) fill_cnt <= fill_cnt + 1'b1;
      iss_valid <= take;
      if (take) map_q[in.inst.dest] <= fl_head;
    end
  end

  // Sources read the map before this instruction's own update
  always_ff @(posedge clock) begin
    if (take) begin
      iss_rec.rob_idx  <= tail_idx;
      iss_rec.dest_tag <= fl_head;
      iss_rec.src1_tag <= map_q[in.inst.src1];
      iss_rec.src2_tag <= map_q[in.inst.src2];
    end
  end
endmodule

// File: hdl/reorder_buffer.sv
// Reorder buffer

`timescale 1ns/1ps

`include "ooo_macros.svh"

module reorder_buffer
  import ooo_types_pkg::*;
  import ooo_bus_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       alloc_valid,
  input  rob_entry_t alloc_entry,
  input  logic       cmp_valid,
  input  rob_idx_t   cmp_idx,
  output logic       rob_full,
  output rob_idx_t   tail_idx,
  retire_if.src      ret
);
  localparam int CW = $clog2(`OOO_ROB_DEPTH) + 1;

  rob_entry_t                entries [`OOO_ROB_DEPTH];
  logic [`OOO_ROB_DEPTH-1:0] busy;
  logic [`OOO_ROB_DEPTH-1:0] done;
  rob_idx_t                  head, tail;
  logic [CW-1:0]             count;
  logic                      retire;

  assign rob_full = (count == CW'(`OOO_ROB_DEPTH));
  assign tail_idx = tail;

  ////////////////////////////////////////////////////////////////////////////
  // Head retirement in strict program order
  ////////////////////////////////////////////////////////////////////////////

  assign ret.valid = busy[head] && done[head];
  assign retire    = ret.valid && ret.ready;

  always_comb begin
    ret.rec.dest    = entries[head].dest;
    ret.rec.tag     = entries[head].tag;
    ret.rec.old_tag = entries[head].old_tag;
  end

  // Slot payload
  always_ff @(posedge clock) begin
    if (alloc_valid) entries[tail] <= alloc_entry;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy  <= '0;
      done  <= '0;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (alloc_valid) begin
        busy[tail] <= 1'b1;
        done[tail] <= 1'b0;
        tail       <= tail + 1'b1; // Eight slots wrap on their own
      end

      // Completions arrive in any order
      if (cmp_valid) done[cmp_idx] <= 1'b1;

      if (retire) begin
        busy[head] <= 1'b0;
        head       <= head + 1'b1;
      end

      case ({alloc_valid, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end
endmodule

// File: hdl/retire_stage.sv
// Retire stage

`timescale 1ns/1ps

`include "ooo_macros.svh"

module retire_stage
  import ooo_types_pkg::*;
  import ooo_bus_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  retire_if.dst       in,
  output logic        free_valid,
  output phys_tag_t   free_tag,
  output logic        ret_valid,
  input  logic        ret_ready,
  output retire_rec_t ret_rec,
  output logic [15:0] retired_count
);
  logic q_empty, q_full;
  logic push, pop;

  assign in.ready = !q_full;
  assign push     = in.valid && in.ready;

  // Old tag goes back to the free list as the record enters the queue
  assign free_valid = push;
  assign free_tag   = in.rec.old_tag;

  assign ret_valid = !q_empty;
  assign pop       = ret_valid && ret_ready;

  ring_queue #(
    .payload_t (retire_rec_t),
    .DEPTH     (`OOO_RQ_DEPTH)
  ) u_retire_queue (
    .clock     (clock),
    .reset     (reset),
    .push      (push),
    .push_data (in.rec),
    .pop       (pop),
    .pop_data  (ret_rec),
    .empty     (q_empty),
    .full      (q_full)
  );

  always_ff @(posedge clock) begin
    if (reset)     retired_count <= '0;
    else if (push) retired_count <= retired_count + 1'b1;
  end
endmodule

// File: hdl/ring_queue.sv
// Circular FIFO

`timescale 1ns/1ps

module ring_queue #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     full
);
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t      mem [DEPTH];
  logic [AW-1:0] head, tail;
  logic [AW:0]   count;
  logic          do_push, do_pop;

  // Advance a pointer with wrap at DEPTH
  function automatic logic [AW-1:0] bump(input logic [AW-1:0] p);
    return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign empty    = (count == '0);
  assign full     = (count == (AW+1)'(DEPTH));
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign pop_data = mem[head]; // First word falls through

  always_ff @(posedge clock) begin
    if (do_push) mem[tail] <= push_data;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (do_push) tail <= bump(tail);
      if (do_pop)  head <= bump(head);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end
endmodule

// File: ooo_macros.svh
// Core sizing macros

`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// Architectural register file size
`define OOO_NUM_ARCH 8

// Physical tag pool covering arch regs and free list
`define OOO_NUM_PR 16

`define OOO_ROB_DEPTH 8 // Reorder buffer slots

`define OOO_RQ_DEPTH 4 // Retire queue toward the consumer

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module ooo_core_tb -Mdir obj_dir -o ooo_core_sim
./obj_dir/ooo_core_sim > sim.log 2>&1
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation finished without failures"

// File: src.f
+incdir+.
hdl/ooo_types_pkg.sv
hdl/ooo_bus_pkg.sv
hdl/rename_if.sv
hdl/ring_queue.sv
hdl/dispatch_stage.sv
hdl/rename_unit.sv
hdl/reorder_buffer.sv
hdl/retire_stage.sv
hdl/ooo_core.sv
test/ooo_core_tb.sv

// File: test/ooo_core_tb.sv
// Out-of-order core testbench

`timescale 1ns/1ps

`include "ooo_macros.svh"

module ooo_core_tb
  import ooo_types_pkg::*;
  import ooo_bus_pkg::*;
();
  logic        clock, reset;
  logic        disp_valid, disp_ready;
  arch_reg_t   disp_dest, disp_src1, disp_src2;
  logic        iss_valid;
  rob_idx_t    iss_rob_idx;
  phys_tag_t   iss_dest_tag, iss_src1_tag, iss_src2_tag;
  logic        cmp_valid;
  rob_idx_t    cmp_rob_idx;
  logic        ret_valid, ret_ready;
  arch_reg_t   ret_arch;
  phys_tag_t   ret_tag, ret_old_tag;
  logic [15:0] retired_count;

  integer      seed = 32'hd4545c28;
  int unsigned errors, checks, test_fails;
  bit          timed_out;
  int          to_send;                       // Beats still to be accepted
  int unsigned valid_pct, ready_pct, cmp_pct; // Traffic mix per test

  // Reference model state
  phys_tag_t   model_map [`OOO_NUM_ARCH];
  phys_tag_t   model_free [$];
  issue_rec_t  exp_iss [$];
  retire_rec_t exp_ret [$];
  rob_idx_t    pending [$];                   // Issued but not yet completed
  issue_rec_t  e_iss;
  retire_rec_t e_ret;
  phys_tag_t   first_dest [8];
  int unsigned disp_seq, iss_seen, ret_seen, stall_run;
  int unsigned self_src_hits, prior_src_hits, ooo_cmp_hits, recycled_hits;
  int          pick;

  ooo_core u_ooo_core (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random helpers and checks
  ////////////////////////////////////////////////////////////////////////////

  function automatic bit chance(input int unsigned pct);
    logic [31:0] r;
    r = $random(seed);
    return (r % 100) < pct;
  endfunction

  function automatic arch_reg_t rand_reg();
    logic [31:0] r;
    r = $random(seed);
    return arch_reg_t'(r);
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic confirm(input bit cond, input string msg);
    checks++;
    if (!cond) begin
      errors++;
      $display("ERROR at %0t: %s", $time, msg);
    end
  endtask

  task automatic report_test(input string name, input int unsigned errors_before);
    if (errors == errors_before && !timed_out) begin
      $display("test %s: passed", name);
    end else begin
      test_fails++;
      $display("test %s: failed", name);
    end
  endtask

  // Sources are renamed before the destination
  task automatic rename_model();
    e_iss.rob_idx  = rob_idx_t'(disp_seq % `OOO_ROB_DEPTH);
    e_iss.src1_tag = model_map[disp_src1];
    e_iss.src2_tag = model_map[disp_src2];
    e_iss.dest_tag = model_free.pop_front();
    e_ret.dest     = disp_dest;
    e_ret.tag      = e_iss.dest_tag;
    e_ret.old_tag  = model_map[disp_dest];
    // Old tags come back in program order since retirement is in order
    model_free.push_back(e_ret.old_tag);
    model_map[disp_dest] = e_iss.dest_tag;
    if (disp_src1 == disp_dest || disp_src2 == disp_dest) self_src_hits++;
    if (e_iss.src1_tag != phys_tag_t'(disp_src1)) prior_src_hits++;
    if (e_iss.dest_tag < `OOO_NUM_ARCH) recycled_hits++; // Arch tag back in use
    exp_iss.push_back(e_iss);
    exp_ret.push_back(e_ret);
    disp_seq++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor, model and execution units in one clocked process
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    if (reset) begin
      disp_valid <= 1'b0;
      ret_ready  <= 1'b0;
      cmp_valid  <= 1'b0;
      for (int r = 0; r < `OOO_NUM_ARCH; r++) model_map[r] = phys_tag_t'(r);
      model_free.delete();
      for (int t = `OOO_NUM_ARCH; t < `OOO_NUM_PR; t++) model_free.push_back(phys_tag_t'(t));
      exp_iss.delete();
      exp_ret.delete();
      pending.delete();
      disp_seq      = 0;
      iss_seen      = 0;
      ret_seen      = 0;
      stall_run     = 0;
      self_src_hits = 0;
      prior_src_hits = 0;
      ooo_cmp_hits  = 0;
      recycled_hits = 0;
    end else begin
      if (iss_valid) begin
        if (exp_iss.size() == 0) begin
          errors++;
          $display("ERROR at %0t: issue pulse with no accepted dispatch beat", $time);
        end else begin
          e_iss = exp_iss.pop_front();
          check_value("iss_rob_idx", 32'(iss_rob_idx), 32'(e_iss.rob_idx));
          check_value("iss_dest_tag", 32'(iss_dest_tag), 32'(e_iss.dest_tag));
          check_value("iss_src1_tag", 32'(iss_src1_tag), 32'(e_iss.src1_tag));
          check_value("iss_src2_tag", 32'(iss_src2_tag), 32'(e_iss.src2_tag));
        end
        if (iss_seen < 8) first_dest[iss_seen[2:0]] = iss_dest_tag;
        iss_seen++;
        pending.push_back(iss_rob_idx);
      end

      if (ret_valid && ret_ready) begin // In program order
        if (exp_ret.size() == 0) begin
          errors++;
          $display("ERROR at %0t: retire record with no instruction in flight", $time);
        end else begin
          e_ret = exp_ret.pop_front();
          check_value("ret_arch", 32'(ret_arch), 32'(e_ret.dest));
          check_value("ret_tag", 32'(ret_tag), 32'(e_ret.tag));
          check_value("ret_old_tag", 32'(ret_old_tag), 32'(e_ret.old_tag));
        end
        ret_seen++;
      end

      if (disp_valid && disp_ready) begin
        rename_model();
        if (to_send > 0) to_send--;
      end
      stall_run = (disp_valid && !disp_ready) ? stall_run + 1 : 0;

      // New beat only once the last one is taken
      if (!disp_valid || disp_ready) begin
        if (to_send > 0 && chance(valid_pct)) begin
          disp_valid <= 1'b1;
          disp_dest  <= rand_reg();
          disp_src1  <= rand_reg();
          disp_src2  <= rand_reg();
        end else begin
          disp_valid <= 1'b0;
        end
      end
      ret_ready <= chance(ready_pct);

      cmp_valid <= 1'b0;
      if (pending.size() != 0 && chance(cmp_pct)) begin
        pick = rand_below(pending.size());
        if (pick != 0) ooo_cmp_hits++; // Younger than the oldest pending
        cmp_valid   <= 1'b1;
        cmp_rob_idx <= pending[pick];
        pending.delete(pick);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequence control
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    reset <= 1'b1;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
  endtask

  task automatic set_traffic(input int n, input int unsigned v, input int unsigned r,
                             input int unsigned c);
    to_send   = n;
    valid_pct = v;
    ready_pct = r;
    cmp_pct   = c;
  endtask

  function automatic bit in_flight();
    return to_send != 0 || disp_valid || exp_iss.size() != 0 || pending.size() != 0
           || exp_ret.size() != 0 || ret_valid;
  endfunction

  task automatic wait_drained(input int unsigned limit);
    int unsigned n;
    n = 0;
    if (timed_out) return;
    do begin
      @(negedge clock);
      n++;
    end while (in_flight() && n < limit);
    if (in_flight()) begin
      timed_out = 1'b1;
      $display("TIMEOUT: instructions still in flight after %0d cycles", limit);
    end
  endtask

  task automatic wait_stall(input int unsigned cycles, input int unsigned limit);
    int unsigned n;
    n = 0;
    if (timed_out) return;
    while (stall_run < cycles && n < limit) begin
      @(negedge clock);
      n++;
    end
    if (stall_run < cycles) begin
      timed_out = 1'b1;
      $display("TIMEOUT: dispatch never stalled under retire back-pressure");
    end
  endtask

  initial begin
    int unsigned err0, acc0, ret0;
    reset       = 1'b1;
    disp_valid  = 1'b0;
    disp_dest   = '0;
    disp_src1   = '0;
    disp_src2   = '0;
    cmp_valid   = 1'b0;
    cmp_rob_idx = '0;
    ret_ready   = 1'b0;
    errors      = 0;
    checks      = 0;
    test_fails  = 0;
    timed_out   = 1'b0;
    set_traffic(0, 0, 0, 0);

    err0 = errors;
    apply_reset();
    check_value("disp_ready after reset", 32'(disp_ready), 0);
    check_value("iss_valid after reset", 32'(iss_valid), 0);
    check_value("ret_valid after reset", 32'(ret_valid), 0);
    check_value("retired_count after reset", 32'(retired_count), 0);
    set_traffic(8, 100, 100, 60);
    wait_drained(1000);
    for (int i = 0; i < 8; i++) begin
      check_value("first dest tags", 32'(first_dest[i]), 32'(`OOO_NUM_ARCH + i));
    end
    report_test("reset_state", err0);

    err0 = errors;
    set_traffic(200, 70, 100, 50);
    wait_drained(3000);
    confirm(self_src_hits != 0, "no instruction read its own destination");
    confirm(prior_src_hits != 0, "no source read a renamed register");
    report_test("renaming", err0);

    err0 = errors;
    set_traffic(150, 80, 60, 40);
    wait_drained(3000);
    confirm(ooo_cmp_hits != 0, "completions never came out of order");
    report_test("in_order_retire", err0);

    err0 = errors;
    acc0 = recycled_hits;
    set_traffic(64, 100, 100, 70);
    wait_drained(2000);
    confirm(recycled_hits != acc0, "no freed tag was issued again");
    report_test("tag_recycling", err0);

    // ROB, retire queue and skid register fill up until dispatch stalls
    err0 = errors;
    acc0 = disp_seq;
    ret0 = ret_seen;
    set_traffic(1000, 100, 0, 75);
    wait_stall(40, 600);
    check_value("beats taken under back-pressure", disp_seq - acc0,
                `OOO_ROB_DEPTH + `OOO_RQ_DEPTH + 1);
    check_value("beats waiting for rename", 32'(exp_iss.size()), 1);
    set_traffic(0, 100, 100, 75);
    wait_drained(1000);
    check_value("records retired after release", ret_seen - ret0, disp_seq - acc0);
    report_test("back_pressure", err0);

    err0 = errors;
    check_value("retired_count", 32'(retired_count), ret_seen);
    check_value("retire handshakes", ret_seen, disp_seq);
    report_test("counter", err0);

    $display("tests 6, failed %0d, checks %0d, errors %0d", test_fails, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end
endmodule
